// ==== hdl/rvPkg.sv ====
package rvPkg;

	// Datapath and memory widths
	localparam int XLen = 32;
	localparam int RegIdxW = 5;
	localparam int ImemAddrW = 10;
	localparam int DmemAddrW = 6;

	// Major opcodes of the supported subset
	localparam logic [6:0] OpReg = 7'b0110011;
	localparam logic [6:0] OpImm = 7'b0010011;
	localparam logic [6:0] OpLoad = 7'b0000011;
	localparam logic [6:0] OpStore = 7'b0100011;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpJal = 7'b1101111;

	// Funct3 values, R-type and branch share the field
	localparam logic [2:0] Funct3Add = 3'b000;
	localparam logic [2:0] Funct3Slt = 3'b010;
	localparam logic [2:0] Funct3Xor = 3'b100;
	localparam logic [2:0] Funct3Or = 3'b110;
	localparam logic [2:0] Funct3And = 3'b111;
	localparam logic [2:0] Funct3Beq = 3'b000;
	localparam logic [2:0] Funct3Bne = 3'b001;
	// Selects SUB over ADD
	localparam logic [6:0] Funct7Sub = 7'b0100000;

	// ALU operation codes
	localparam int AluOpW = 3;
	localparam logic [AluOpW-1:0] AluAdd = 3'd0;
	localparam logic [AluOpW-1:0] AluSub = 3'd1;
	localparam logic [AluOpW-1:0] AluAnd = 3'd2;
	localparam logic [AluOpW-1:0] AluOr = 3'd3;
	localparam logic [AluOpW-1:0] AluXor = 3'd4;
	localparam logic [AluOpW-1:0] AluSlt = 3'd5;

	// ADDI x0,x0,0
	localparam logic [XLen-1:0] NopInstr = 32'h0000_0013;

	// One instruction word seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] immHi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic imm12;
			logic [5:0] imm10to5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4to1;
			logic imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic imm20;
			logic [9:0] imm10to1;
			logic imm11;
			logic [7:0] imm19to12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} instrWordT;

endpackage

// ==== hdl/regFile.sv ====
module regFile import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic [RegIdxW-1:0] ra1,
	input logic [RegIdxW-1:0] ra2,
	input logic we,
	input logic [RegIdxW-1:0] wa,
	input logic [XLen-1:0] wd,
	output logic [XLen-1:0] rd1,
	output logic [XLen-1:0] rd2
);

	// x1 to x31, x0 has no storage
	logic [XLen-1:0] regs [1:31];

	// Same-cycle write shows up on the read port
	function automatic logic [XLen-1:0] readPort(input logic [RegIdxW-1:0] ra);
		if (ra == '0) begin
			return '0;
		end else if (we && (wa == ra)) begin
			return wd;
		end
		return regs[ra];
	endfunction

	always_comb begin
		rd1 = readPort(ra1);
		rd2 = readPort(ra2);
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

endmodule

// ==== hdl/fetchStage.sv ====
module fetchStage import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic stall,
	input logic jumpTaken,
	input logic [XLen-1:0] jumpTarget,
	input logic brFlush,
	input logic [XLen-1:0] brTarget,
	input logic [XLen-1:0] iMemData,
	output logic [ImemAddrW-1:0] iMemAddr,
	output logic [XLen-1:0] ifPc,
	output instrWordT ifInstr
);

	logic [XLen-1:0] pc;
	logic [XLen-1:0] pcNext;
	logic redirect;

	// Byte PC, instruction memory takes a word index
	assign iMemAddr = pc[ImemAddrW+1:2];

	assign redirect = brFlush || jumpTaken;

	// Branch in MEM is older than JAL in EX so it wins
	always_comb begin
		if (brFlush) begin
			pcNext = brTarget;
		end else if (jumpTaken) begin
			pcNext = jumpTarget;
		end else begin
			pcNext = pc + 32'd4;
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
			ifPc <= '0;
			ifInstr <= NopInstr;
		end else if (redirect) begin
			pc <= pcNext;
			// Wrong-path fetch becomes a bubble
			ifInstr <= NopInstr;
		end else if (!stall) begin
			pc <= pcNext;
			ifPc <= pc;
			ifInstr <= iMemData;
		end
	end

endmodule

// ==== hdl/decodeStage.sv ====
module decodeStage import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic [XLen-1:0] ifPc,
	input instrWordT ifInstr,
	input logic jumpTaken,
	input logic brFlush,
	input logic [RegIdxW-1:0] wbRd,
	input logic [XLen-1:0] wbData,
	input logic wbRegWrite,
	output logic stall,
	output logic [XLen-1:0] exPc,
	output logic [RegIdxW-1:0] exRs1,
	output logic [RegIdxW-1:0] exRs2,
	output logic [RegIdxW-1:0] exRd,
	output logic [XLen-1:0] exA,
	output logic [XLen-1:0] exB,
	output logic [XLen-1:0] exImm,
	output logic [AluOpW-1:0] exAluOp,
	output logic exUseImm,
	output logic exRegWrite,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exBranch,
	output logic exBranchNe,
	output logic exJump,
	output logic exValid
);

	logic [6:0] opcode;
	logic isReg;
	logic isImm;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic isJal;
	logic useRs1;
	logic useRs2;
	logic regWrite;
	logic valid;
	logic bubble;
	logic [AluOpW-1:0] aluOp;
	logic [XLen-1:0] imm;
	logic [XLen-1:0] rd1;
	logic [XLen-1:0] rd2;

	// Source reads use the R view for every format
	regFile uRegFile (
		.CLK(CLK),
		.RSTn(RSTn),
		.ra1(ifInstr.r.rs1),
		.ra2(ifInstr.r.rs2),
		.we(wbRegWrite),
		.wa(wbRd),
		.wd(wbData),
		.rd1(rd1),
		.rd2(rd2)
	);

	assign opcode = ifInstr.r.opcode;
	assign isReg = (opcode == OpReg);
	assign isImm = (opcode == OpImm);
	assign isLoad = (opcode == OpLoad);
	assign isStore = (opcode == OpStore);
	assign isBranch = (opcode == OpBranch);
	assign isJal = (opcode == OpJal);

	assign useRs1 = isReg || isImm || isLoad || isStore || isBranch;
	assign useRs2 = isReg || isStore || isBranch;
	// Writes to x0 are dropped here
	assign regWrite = (isReg || isImm || isLoad || isJal) && (ifInstr.r.rd != '0);
	// Flush NOPs and unknown opcodes are not counted
	assign valid = (useRs1 || isJal) && (ifInstr != NopInstr);

	// ALU control, op class first and funct decode for R-type only
	always_comb begin
		aluOp = AluAdd;
		if (isReg) begin
			case (ifInstr.r.funct3)
				Funct3Add: aluOp = (ifInstr.r.funct7 == Funct7Sub) ? AluSub : AluAdd;
				Funct3Xor: aluOp = AluXor;
				Funct3Or: aluOp = AluOr;
				Funct3And: aluOp = AluAnd;
				Funct3Slt: aluOp = AluSlt;
				default: aluOp = AluAdd;
			endcase
		end
	end

	// Immediate per format view
	always_comb begin
		if (isStore) begin
			imm = {{20{ifInstr.s.immHi[6]}}, ifInstr.s.immHi, ifInstr.s.immLo};
		end else if (isBranch) begin
			imm = {{19{ifInstr.b.imm12}}, ifInstr.b.imm12, ifInstr.b.imm11,
				ifInstr.b.imm10to5, ifInstr.b.imm4to1, 1'b0};
		end else if (isJal) begin
			imm = {{11{ifInstr.j.imm20}}, ifInstr.j.imm20, ifInstr.j.imm19to12,
				ifInstr.j.imm11, ifInstr.j.imm10to1, 1'b0};
		end else begin
			imm = {{20{ifInstr.i.imm[11]}}, ifInstr.i.imm};
		end
	end

	// Load in ID/EX feeding this instruction
	assign stall = exMemRead && (exRd != '0) &&
		((useRs1 && (exRd == ifInstr.r.rs1)) || (useRs2 && (exRd == ifInstr.r.rs2)));

	// Load-use hold, or younger than a redirect
	assign bubble = stall || jumpTaken || brFlush;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exBranch <= 1'b0;
			exJump <= 1'b0;
			exValid <= 1'b0;
		end else begin
			exRegWrite <= regWrite && !bubble;
			exMemRead <= isLoad && !bubble;
			exMemWrite <= isStore && !bubble;
			exBranch <= isBranch && !bubble;
			exJump <= isJal && !bubble;
			exValid <= valid && !bubble;
		end
	end

	// ID/EX payload
	always_ff @(posedge CLK) begin
		exPc <= ifPc;
		exRs1 <= ifInstr.r.rs1;
		exRs2 <= ifInstr.r.rs2;
		exRd <= ifInstr.r.rd;
		exA <= rd1;
		exB <= rd2;
		exImm <= imm;
		exAluOp <= aluOp;
		exUseImm <= isImm || isLoad || isStore;
		exBranchNe <= (ifInstr.b.funct3 == Funct3Bne);
	end

endmodule

// ==== hdl/executeStage.sv ====
module executeStage import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic [XLen-1:0] exPc,
	input logic [RegIdxW-1:0] exRs1,
	input logic [RegIdxW-1:0] exRs2,
	input logic [RegIdxW-1:0] exRd,
	input logic [XLen-1:0] exA,
	input logic [XLen-1:0] exB,
	input logic [XLen-1:0] exImm,
	input logic [AluOpW-1:0] exAluOp,
	input logic exUseImm,
	input logic exRegWrite,
	input logic exMemRead,
	input logic exMemWrite,
	input logic exBranch,
	input logic exBranchNe,
	input logic exJump,
	input logic exValid,
	input logic [RegIdxW-1:0] wbRd,
	input logic [XLen-1:0] wbData,
	input logic wbRegWrite,
	output logic jumpTaken,
	output logic [XLen-1:0] jumpTarget,
	output logic brFlush,
	output logic [XLen-1:0] brTarget,
	output logic [XLen-1:0] memAluResult,
	output logic [XLen-1:0] memStoreData,
	output logic [RegIdxW-1:0] memRd,
	output logic memRegWrite,
	output logic memMemRead,
	output logic memJump,
	output logic [XLen-1:0] memLinkPc,
	output logic memValid,
	output logic [DmemAddrW-1:0] dMemAddr,
	output logic dMemWe
);

	logic [XLen-1:0] opA;
	logic [XLen-1:0] fwdB;
	logic [XLen-1:0] opB;
	logic [XLen-1:0] aluOut;
	logic [XLen-1:0] target;
	logic brTaken;
	logic memMemWrite;

	// Youngest producer first, regWrite is never set for x0
	function automatic logic [XLen-1:0] forward(input logic [RegIdxW-1:0] rs,
		input logic [XLen-1:0] idVal);
		if (memRegWrite && (memRd == rs)) begin
			return memAluResult;
		end else if (wbRegWrite && (wbRd == rs)) begin
			return wbData;
		end
		return idVal;
	endfunction

	always_comb begin
		opA = forward(exRs1, exA);
		fwdB = forward(exRs2, exB);
	end

	assign opB = exUseImm ? exImm : fwdB;

	always_comb begin
		case (exAluOp)
			AluSub: aluOut = opA - opB;
			AluAnd: aluOut = opA & opB;
			AluOr: aluOut = opA | opB;
			AluXor: aluOut = opA ^ opB;
			AluSlt: aluOut = {{(XLen-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluOut = opA + opB;
		endcase
	end

	// One adder serves branch and JAL targets
	assign target = exPc + exImm;
	// Compare on register operands, not the immediate path
	assign brTaken = exBranch && (exBranchNe ? (opA != fwdB) : (opA == fwdB));

	// JAL redirects from here
	assign jumpTaken = exJump;
	assign jumpTarget = target;

	// A taken branch in EX/MEM kills the entry behind it
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			memRegWrite <= 1'b0;
			memMemRead <= 1'b0;
			memMemWrite <= 1'b0;
			memJump <= 1'b0;
			memValid <= 1'b0;
			brFlush <= 1'b0;
		end else begin
			memRegWrite <= exRegWrite && !brFlush;
			memMemRead <= exMemRead && !brFlush;
			memMemWrite <= exMemWrite && !brFlush;
			memJump <= exJump && !brFlush;
			memValid <= exValid && !brFlush;
			brFlush <= brTaken && !brFlush;
		end
	end

	// EX/MEM payload
	always_ff @(posedge CLK) begin
		memAluResult <= aluOut;
		memStoreData <= fwdB;
		memRd <= exRd;
		memLinkPc <= exPc + 32'd4;
		brTarget <= target;
	end

	// Data memory is word addressed
	assign dMemAddr = memAluResult[DmemAddrW+1:2];
	assign dMemWe = memMemWrite;

endmodule

// ==== hdl/memWbStage.sv ====
module memWbStage import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic [XLen-1:0] memAluResult,
	input logic [RegIdxW-1:0] memRd,
	input logic memRegWrite,
	input logic memMemRead,
	input logic memJump,
	input logic [XLen-1:0] memLinkPc,
	input logic memValid,
	input logic [XLen-1:0] dMemRData,
	output logic [RegIdxW-1:0] wbRd,
	output logic [XLen-1:0] wbData,
	output logic wbRegWrite,
	output logic rfWe,
	output logic [RegIdxW-1:0] rfWa,
	output logic [XLen-1:0] rfWd,
	output logic [XLen-1:0] numInst
);

	logic wbMemRead;
	logic wbJump;
	logic [XLen-1:0] wbAlu;
	logic [XLen-1:0] wbLoad;
	logic [XLen-1:0] wbLink;

	// Count moves with the MEM/WB load so it lines up with rfWe
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			wbRegWrite <= 1'b0;
			wbMemRead <= 1'b0;
			wbJump <= 1'b0;
			numInst <= '0;
		end else begin
			wbRegWrite <= memRegWrite;
			wbMemRead <= memMemRead;
			wbJump <= memJump;
			numInst <= numInst + {{(XLen-1){1'b0}}, memValid};
		end
	end

	// MEM/WB payload, load data sampled from the same-cycle memory
	always_ff @(posedge CLK) begin
		wbRd <= memRd;
		wbAlu <= memAluResult;
		wbLoad <= dMemRData;
		wbLink <= memLinkPc;
	end

	// Writeback select
	always_comb begin
		if (wbMemRead) begin
			wbData = wbLoad;
		end else if (wbJump) begin
			wbData = wbLink;
		end else begin
			wbData = wbAlu;
		end
	end

	// Register file write port seen outside
	assign rfWe = wbRegWrite;
	assign rfWa = wbRd;
	assign rfWd = wbData;

endmodule

// ==== hdl/rvCore.sv ====
module rvCore import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic [XLen-1:0] iMemData,
	input logic [XLen-1:0] dMemRData,
	output logic [ImemAddrW-1:0] iMemAddr,
	output logic [DmemAddrW-1:0] dMemAddr,
	output logic [XLen-1:0] dMemWData,
	output logic dMemWe,
	output logic rfWe,
	output logic [RegIdxW-1:0] rfWa,
	output logic [XLen-1:0] rfWd,
	output logic [XLen-1:0] numInst
);

	// IF/ID
	logic [XLen-1:0] ifPc;
	instrWordT ifInstr;

	// Hazard and redirect
	logic stall;
	logic jumpTaken;
	logic [XLen-1:0] jumpTarget;
	logic brFlush;
	logic [XLen-1:0] brTarget;

	// ID/EX
	logic [XLen-1:0] exPc;
	logic [RegIdxW-1:0] exRs1;
	logic [RegIdxW-1:0] exRs2;
	logic [RegIdxW-1:0] exRd;
	logic [XLen-1:0] exA;
	logic [XLen-1:0] exB;
	logic [XLen-1:0] exImm;
	logic [AluOpW-1:0] exAluOp;
	logic exUseImm;
	logic exRegWrite;
	logic exMemRead;
	logic exMemWrite;
	logic exBranch;
	logic exBranchNe;
	logic exJump;
	logic exValid;

	// EX/MEM
	logic [XLen-1:0] memAluResult;
	logic [RegIdxW-1:0] memRd;
	logic memRegWrite;
	logic memMemRead;
	logic memJump;
	logic [XLen-1:0] memLinkPc;
	logic memValid;

	// MEM/WB result, shared by forwarding and the register file
	logic [RegIdxW-1:0] wbRd;
	logic [XLen-1:0] wbData;
	logic wbRegWrite;

	fetchStage uFetch (
		.CLK(CLK),
		.RSTn(RSTn),
		.stall(stall),
		.jumpTaken(jumpTaken),
		.jumpTarget(jumpTarget),
		.brFlush(brFlush),
		.brTarget(brTarget),
		.iMemData(iMemData),
		.iMemAddr(iMemAddr),
		.ifPc(ifPc),
		.ifInstr(ifInstr)
	);

	decodeStage uDecode (
		.CLK(CLK),
		.RSTn(RSTn),
		.ifPc(ifPc),
		.ifInstr(ifInstr),
		.jumpTaken(jumpTaken),
		.brFlush(brFlush),
		.wbRd(wbRd),
		.wbData(wbData),
		.wbRegWrite(wbRegWrite),
		.stall(stall),
		.exPc(exPc),
		.exRs1(exRs1),
		.exRs2(exRs2),
		.exRd(exRd),
		.exA(exA),
		.exB(exB),
		.exImm(exImm),
		.exAluOp(exAluOp),
		.exUseImm(exUseImm),
		.exRegWrite(exRegWrite),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.exBranch(exBranch),
		.exBranchNe(exBranchNe),
		.exJump(exJump),
		.exValid(exValid)
	);

	executeStage uExecute (
		.CLK(CLK),
		.RSTn(RSTn),
		.exPc(exPc),
		.exRs1(exRs1),
		.exRs2(exRs2),
		.exRd(exRd),
		.exA(exA),
		.exB(exB),
		.exImm(exImm),
		.exAluOp(exAluOp),
		.exUseImm(exUseImm),
		.exRegWrite(exRegWrite),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.exBranch(exBranch),
		.exBranchNe(exBranchNe),
		.exJump(exJump),
		.exValid(exValid),
		.wbRd(wbRd),
		.wbData(wbData),
		.wbRegWrite(wbRegWrite),
		.jumpTaken(jumpTaken),
		.jumpTarget(jumpTarget),
		.brFlush(brFlush),
		.brTarget(brTarget),
		.memAluResult(memAluResult),
		// Store data register feeds the data memory directly
		.memStoreData(dMemWData),
		.memRd(memRd),
		.memRegWrite(memRegWrite),
		.memMemRead(memMemRead),
		.memJump(memJump),
		.memLinkPc(memLinkPc),
		.memValid(memValid),
		.dMemAddr(dMemAddr),
		.dMemWe(dMemWe)
	);

	memWbStage uMemWb (
		.CLK(CLK),
		.RSTn(RSTn),
		.memAluResult(memAluResult),
		.memRd(memRd),
		.memRegWrite(memRegWrite),
		.memMemRead(memMemRead),
		.memJump(memJump),
		.memLinkPc(memLinkPc),
		.memValid(memValid),
		.dMemRData(dMemRData),
		.wbRd(wbRd),
		.wbData(wbData),
		.wbRegWrite(wbRegWrite),
		.rfWe(rfWe),
		.rfWa(rfWa),
		.rfWd(rfWd),
		.numInst(numInst)
	);

endmodule

// ==== tb/tbClock.sv ====
module tbClock (
	output logic CLK,
	output logic RSTn
);

	int resetCycles = 0;

	// Free-running clock, period 40
	initial begin
		CLK = 1'b0;
	end

	always #20 CLK = ~CLK;

	// Reset held for the first 8 rising edges
	initial begin
		RSTn = 1'b1;
	end

	always @(posedge CLK) begin
		if (resetCycles < 8) begin
			resetCycles <= resetCycles + 1;
		end
		RSTn <= (resetCycles < 7);
	end

endmodule

// ==== tb/core_properties.sv ====
module core_properties import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic rfWe,
	input logic [RegIdxW-1:0] rfWa,
	input logic dMemWe,
	input logic [XLen-1:0] numInst
);

	// Write strobes are quiet one edge after any reset edge
	quietInReset: assert property (@(posedge CLK) RSTn |=> !rfWe && !dMemWe)
		else $error("Register or memory write strobe high during reset");

	// x0 is never a write target at the retire port
	noWriteToZero: assert property (@(posedge CLK) disable iff (RSTn) rfWe |-> rfWa != '0)
		else $error("Retire port wrote register x0");

	// At most one retirement per cycle
	// A retire-port write always comes with its own count step
	countStep: assert property (@(posedge CLK) disable iff (RSTn)
		(!rfWe && (numInst == $past(numInst))) || (numInst == $past(numInst) + 1))
		else $error("Retired-instruction count out of step with the retire port");

endmodule

bind rvCore core_properties uProps (
	.CLK(CLK),
	.RSTn(RSTn),
	.rfWe(rfWe),
	.rfWa(rfWa),
	.dMemWe(dMemWe),
	.numInst(numInst)
);

// ==== tb/tbCore.sv ====
module tbCore import rvPkg::*;;

	typedef enum int {RowWrite, RowStore, RowBranch, RowSkip, RowFill} rowKindT;

	logic CLK;
	logic RSTn;
	logic [XLen-1:0] iMemData;
	logic [XLen-1:0] dMemRData;
	logic [ImemAddrW-1:0] iMemAddr;
	logic [DmemAddrW-1:0] dMemAddr;
	logic [XLen-1:0] dMemWData;
	logic dMemWe;
	logic rfWe;
	logic [RegIdxW-1:0] rfWa;
	logic [XLen-1:0] rfWd;
	logic [XLen-1:0] numInst;

	// Program table, row index is the instruction word address
	logic [XLen-1:0] rowInstr [0:(1<<ImemAddrW)-1];
	rowKindT rowKind [0:(1<<ImemAddrW)-1];
	// Register index for writes, word address for stores
	logic [DmemAddrW-1:0] rowDest [0:(1<<ImemAddrW)-1];
	logic [XLen-1:0] rowVal [0:(1<<ImemAddrW)-1];
	int numRows;

	logic [XLen-1:0] dataMem [0:(1<<DmemAddrW)-1];

	// Retire events seen at the DUT ports
	logic [RegIdxW-1:0] wrRegQ [$];
	logic [XLen-1:0] wrValQ [$];
	logic [DmemAddrW-1:0] stAddrQ [$];
	logic [XLen-1:0] stValQ [$];

	int writeErrors;
	int storeErrors;
	int countErrors;
	int otherErrors;
	int cycles;
	int timeoutLimit;

	tbClock clockGen (
		.CLK(CLK),
		.RSTn(RSTn)
	);

	rvCore DUT (
		.CLK(CLK),
		.RSTn(RSTn),
		.iMemData(iMemData),
		.dMemRData(dMemRData),
		.iMemAddr(iMemAddr),
		.dMemAddr(dMemAddr),
		.dMemWData(dMemWData),
		.dMemWe(dMemWe),
		.rfWe(rfWe),
		.rfWa(rfWa),
		.rfWd(rfWd),
		.numInst(numInst)
	);

	// Instruction encoders straight from the RV32I formats
	function automatic logic [XLen-1:0] rType(input logic [6:0] funct7, input logic [2:0] funct3,
		input int rd, input int rs1, input int rs2);
		return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], OpReg};
	endfunction

	function automatic logic [XLen-1:0] iType(input logic [6:0] opcode, input logic [2:0] funct3,
		input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
	endfunction

	// SW, funct3 010 is a word access
	function automatic logic [XLen-1:0] sType(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OpStore};
	endfunction

	function automatic logic [XLen-1:0] bType(input logic [2:0] funct3, input int rs1,
		input int rs2, input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], funct3, off[4:1], off[11], OpBranch};
	endfunction

	function automatic logic [XLen-1:0] jType(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OpJal};
	endfunction

	task automatic addRow(input logic [XLen-1:0] instr, input rowKindT kind, input int dest,
		input int value);
		rowInstr[numRows] = instr;
		rowKind[numRows] = kind;
		rowDest[numRows] = dest[DmemAddrW-1:0];
		rowVal[numRows] = value;
		numRows++;
	endtask

	task automatic loadProgram();
		numRows = 0;
		// ALU chain, each op reads the last result and the one before it
		addRow(iType(OpImm, Funct3Add, 1, 0, 5), RowWrite, 1, 5);
		addRow(iType(OpImm, Funct3Add, 2, 1, 7), RowWrite, 2, 12);
		addRow(rType(7'b0, Funct3Add, 3, 2, 1), RowWrite, 3, 17);
		addRow(rType(Funct7Sub, Funct3Add, 4, 3, 2), RowWrite, 4, 5);
		addRow(rType(7'b0, Funct3Xor, 5, 4, 3), RowWrite, 5, 20);
		addRow(rType(7'b0, Funct3Or, 6, 5, 4), RowWrite, 6, 21);
		addRow(rType(7'b0, Funct3And, 7, 6, 5), RowWrite, 7, 20);
		addRow(rType(7'b0, Funct3Slt, 8, 7, 6), RowWrite, 8, 1);
		addRow(iType(OpImm, Funct3Add, 9, 0, -3), RowWrite, 9, -3);
		// Signed compare, -3 < 1
		addRow(rType(7'b0, Funct3Slt, 10, 9, 8), RowWrite, 10, 1);
		// Store then load back, base 8 plus 4 is word 3
		addRow(iType(OpImm, Funct3Add, 11, 0, 8), RowWrite, 11, 8);
		addRow(sType(7, 11, 4), RowStore, 3, 20);
		addRow(iType(OpLoad, 3'b010, 12, 11, 4), RowWrite, 12, 20);
		// Load-use on one operand
		addRow(rType(7'b0, Funct3Add, 13, 12, 1), RowWrite, 13, 25);
		addRow(sType(13, 0, 0), RowStore, 0, 25);
		addRow(iType(OpLoad, 3'b010, 14, 0, 0), RowWrite, 14, 25);
		// Load-use on both operands
		addRow(rType(7'b0, Funct3Add, 15, 14, 14), RowWrite, 15, 50);
		// Taken BEQ over three rows
		addRow(bType(Funct3Beq, 1, 4, 16), RowBranch, 0, 0);
		addRow(iType(OpImm, Funct3Add, 20, 0, 1), RowSkip, 0, 0);
		addRow(iType(OpImm, Funct3Add, 21, 0, 2), RowSkip, 0, 0);
		addRow(iType(OpImm, Funct3Add, 22, 0, 3), RowSkip, 0, 0);
		// Taken BNE, 5 against 12
		addRow(bType(Funct3Bne, 1, 2, 16), RowBranch, 0, 0);
		addRow(iType(OpImm, Funct3Add, 20, 0, 4), RowSkip, 0, 0);
		addRow(iType(OpImm, Funct3Add, 21, 0, 5), RowSkip, 0, 0);
		addRow(iType(OpImm, Funct3Add, 22, 0, 6), RowSkip, 0, 0);
		// Not taken, equal operands
		addRow(bType(Funct3Bne, 1, 4, 16), RowBranch, 0, 0);
		addRow(iType(OpImm, Funct3Add, 16, 0, 85), RowWrite, 16, 85);
		// JAL at byte 108 links 112 and lands on row 30
		addRow(jType(17, 12), RowWrite, 17, 112);
		addRow(iType(OpImm, Funct3Add, 20, 0, 7), RowSkip, 0, 0);
		addRow(iType(OpImm, Funct3Add, 21, 0, 8), RowSkip, 0, 0);
		addRow(rType(7'b0, Funct3Add, 18, 17, 16), RowWrite, 18, 197);
		addRow(NopInstr, RowFill, 0, 0);
		addRow(NopInstr, RowFill, 0, 0);
	endtask

	task automatic checkWrite(input int row, input logic [RegIdxW-1:0] gotReg,
		input logic [XLen-1:0] gotVal, input logic [RegIdxW-1:0] expReg,
		input logic [XLen-1:0] expVal);
		if ((gotReg !== expReg) || (gotVal !== expVal)) begin
			$display("** Error @ %0t: row %0d wrote x%0d = 0x%08h, expected x%0d = 0x%08h",
				$time, row, gotReg, gotVal, expReg, expVal);
			writeErrors++;
		end
	endtask

	task automatic checkStore(input int row, input logic [DmemAddrW-1:0] gotAddr,
		input logic [XLen-1:0] gotVal, input logic [DmemAddrW-1:0] expAddr,
		input logic [XLen-1:0] expVal);
		if ((gotAddr !== expAddr) || (gotVal !== expVal)) begin
			$display("** Error @ %0t: row %0d stored 0x%08h at word %0d, expected 0x%08h at %0d",
				$time, row, gotVal, gotAddr, expVal, expAddr);
			storeErrors++;
		end
	endtask

	task automatic checkCount(input logic [XLen-1:0] got, input logic [XLen-1:0] expected);
		if (got !== expected) begin
			$display("** Error @ %0t: numInst is %0d, expected %0d", $time, got, expected);
			countErrors++;
		end
	endtask

	// Instruction memory answers in the same cycle, NOP past the table
	always_comb begin
		if (int'(iMemAddr) < numRows) begin
			iMemData = rowInstr[iMemAddr];
		end else begin
			iMemData = NopInstr;
		end
	end

	// Data memory, cleared in reset
	assign dMemRData = dataMem[dMemAddr];

	always @(posedge CLK) begin
		if (RSTn) begin
			for (int a = 0; a < (1 << DmemAddrW); a++) begin
				dataMem[a] <= '0;
			end
		end else if (dMemWe) begin
			dataMem[dMemAddr] <= dMemWData;
		end
	end

	// Sampled mid-cycle, register writes ahead of stores
	always @(negedge CLK) begin
		if (!RSTn) begin
			if (rfWe) begin
				wrRegQ.push_back(rfWa);
				wrValQ.push_back(rfWd);
			end
			if (dMemWe) begin
				stAddrQ.push_back(dMemAddr);
				stValQ.push_back(dMemWData);
			end
		end
	end

	// Cycle budget
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if ((timeoutLimit > 0) && (cycles >= timeoutLimit)) begin
			$display("Timeout: the program did not retire within %0d cycles", timeoutLimit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin : mainSequence
		logic [RegIdxW-1:0] gotReg;
		logic [XLen-1:0] gotVal;
		logic [DmemAddrW-1:0] gotAddr;
		logic [XLen-1:0] expectCount;
		int totalErrors;
		loadProgram();
		timeoutLimit = numRows * 6 + 40;
		// Skipped and filler rows never retire
		expectCount = '0;
		for (int i = 0; i < numRows; i++) begin
			if ((rowKind[i] != RowSkip) && (rowKind[i] != RowFill)) begin
				expectCount = expectCount + 1;
			end
		end
		@(negedge RSTn);
		// Match each write or store row with the next event of its kind
		for (int i = 0; i < numRows; i++) begin
			if (rowKind[i] == RowWrite) begin
				while (wrRegQ.size() == 0) begin
					@(posedge CLK);
				end
				gotReg = wrRegQ.pop_front();
				gotVal = wrValQ.pop_front();
				checkWrite(i, gotReg, gotVal, rowDest[i][RegIdxW-1:0], rowVal[i]);
			end else if (rowKind[i] == RowStore) begin
				while (stAddrQ.size() == 0) begin
					@(posedge CLK);
				end
				gotAddr = stAddrQ.pop_front();
				gotVal = stValQ.pop_front();
				checkStore(i, gotAddr, gotVal, rowDest[i], rowVal[i]);
			end
		end
		// Drain the five stages so stray writes show up
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		checkCount(numInst, expectCount);
		while (wrRegQ.size() > 0) begin
			gotReg = wrRegQ.pop_front();
			gotVal = wrValQ.pop_front();
			$display("Unexpected register write: x%0d got 0x%08h after the last table row",
				gotReg, gotVal);
			otherErrors++;
		end
		while (stAddrQ.size() > 0) begin
			gotAddr = stAddrQ.pop_front();
			gotVal = stValQ.pop_front();
			$display("Unexpected store: 0x%08h to word %0d after the last table row",
				gotVal, gotAddr);
			otherErrors++;
		end
		totalErrors = writeErrors + storeErrors + countErrors + otherErrors;
		$display("Errors: write %0d, store %0d, count %0d, other %0d",
			writeErrors, storeErrors, countErrors, otherErrors);
		if (totalErrors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
hdl/rvPkg.sv
hdl/regFile.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/rvCore.sv
tb/tbClock.sv
tb/core_properties.sv
tb/tbCore.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tbCore
FILELIST := tb.f
OBJDIR   := obj_dir
SIMBIN   := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	-./$(SIMBIN) 2>&1 | tee $(LOG)
	@! grep -q "CHECKS FAILED" $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
